/* Makefile */
TOP = uart_tb

all: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "All tests passed"

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build lint clean

/* bench/uart_tb.sv */
// uart testbench covering reset state, loopback, tx fifo status, rx overflow, framing and glitches
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_tb;

    localparam int CLK_NS      = 20;
    localparam int BIT_CLKS    = 32;  // one bit period at divisor 32
    localparam int N_FRAMES    = 42;  // 20 + 9 + 10 + 3
    localparam int WATCHDOG_NS = 2 * N_FRAMES * 10 * BIT_CLKS * CLK_NS + 20000;
    localparam int LVL_W       = $clog2(`UART_FIFO_DEPTH + 1);

    logic                       clk;
    logic                       rst_n;
    logic [`UART_DATA_BITS-1:0] tx_data;
    logic                       tx_valid;
    logic                       tx_ready;
    logic                       tx_full;
    logic                       tx_empty;
    logic [LVL_W-1:0]           tx_level;
    logic [`UART_DATA_BITS-1:0] rx_data;
    logic                       rx_valid;
    logic                       rx_ready;
    logic                       rx_full;
    logic                       rx_empty;
    logic [LVL_W-1:0]           rx_level;
    logic                       tx_line;
    logic                       ser_line;   // bench serial driver
    logic                       sel_loop;   // 1 routes o_tx back to i_rx
    logic [`UART_DATA_BITS-1:0] exp_q[$];   // bytes the host should pop, in order
    logic [`UART_DATA_BITS-1:0] exp_byte;
    logic [`UART_DATA_BITS-1:0] b;
    int                         seed = 3138;
    int                         i;
    int                         lvl;
    int                         val_errs  = 0;
    int                         mon_errs  = 0;
    int                         prop_errs = 0;

    uart_top DUT (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_baud_div (16'd32),
        .i_tx_data  (tx_data),
        .i_tx_valid (tx_valid),
        .o_tx_ready (tx_ready),
        .o_tx_full  (tx_full),
        .o_tx_empty (tx_empty),
        .o_tx_level (tx_level),
        .o_rx_data  (rx_data),
        .o_rx_valid (rx_valid),
        .i_rx_ready (rx_ready),
        .o_rx_full  (rx_full),
        .o_rx_empty (rx_empty),
        .o_rx_level (rx_level),
        .i_rx       (sel_loop ? tx_line : ser_line),
        .o_tx       (tx_line)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    // an accepted push leaves at least one byte in the transmit fifo
    assert property (@(posedge clk) disable iff (!rst_n)
        (tx_valid && tx_ready) |=> !tx_empty)
    else begin
        prop_errs++;
        $display("accepted push left the transmit fifo empty at %0t", $time);
    end

    // host side pops are checked against the model queue
    always @(negedge clk) begin
        if (rst_n && rx_valid && rx_ready) begin
            assert (exp_q.size() != 0) else begin
                mon_errs++;
                $display("unexpected byte %h popped from the receive fifo at %0t",
                         rx_data, $time);
            end
            if (exp_q.size() != 0) begin
                exp_byte = exp_q.pop_front();
                assert (rx_data == exp_byte) else begin
                    mon_errs++;
                    $display("ERR %0t o_rx_data expected %h got %h", $time, exp_byte, rx_data);
                end
            end
        end
    end

    task automatic check_val(input string name, input logic [7:0] exp_v, input logic [7:0] got);
        assert (got === exp_v) else begin
            val_errs++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp_v, got);
        end
    endtask

    task automatic push_tx(input logic [7:0] d);
        @(negedge clk);
        while (!tx_ready) @(negedge clk);
        @(posedge clk);
        tx_data  <= d;
        tx_valid <= 1'b1;
        @(posedge clk);
        tx_valid <= 1'b0;
    endtask

    // start bit, eight data bits lsb first, stop bit, then back to idle
    task automatic send_frame(input logic [7:0] d, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, d, 1'b0};
        for (int k = 0; k < 10; k++) begin
            @(posedge clk);
            ser_line <= frame[k];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
        @(posedge clk);
        ser_line <= 1'b1;
    endtask

    task automatic drain_wait();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    initial begin
        rst_n    = 1'b0;
        tx_data  = '0;
        tx_valid = 1'b0;
        rx_ready = 1'b0;
        ser_line = 1'b1;
        sel_loop = 1'b1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_val("o_tx", 8'd1, 8'(tx_line));
        check_val("o_tx_empty", 8'd1, 8'(tx_empty));
        check_val("o_tx_full", 8'd0, 8'(tx_full));
        check_val("o_tx_level", 8'd0, 8'(tx_level));
        check_val("o_tx_ready", 8'd1, 8'(tx_ready));
        check_val("o_rx_empty", 8'd1, 8'(rx_empty));
        check_val("o_rx_full", 8'd0, 8'(rx_full));
        check_val("o_rx_level", 8'd0, 8'(rx_level));
        check_val("o_rx_valid", 8'd0, 8'(rx_valid));

        @(posedge clk);
        rx_ready <= 1'b1;
        for (i = 0; i < 20; i++) begin
            b = 8'($random(seed));
            exp_q.push_back(b);
            push_tx(b);
        end
        drain_wait();

        // one byte goes out first, the burst then fills the fifo behind it
        b = 8'($random(seed));
        exp_q.push_back(b);
        push_tx(b);
        @(negedge clk);
        while (!tx_empty) @(negedge clk);
        lvl = 0;
        for (i = 0; i < 9; i++) begin
            @(posedge clk);
            b = 8'($random(seed));
            tx_data  <= b;
            tx_valid <= 1'b1;
            @(negedge clk);
            check_val("o_tx_level", 8'(lvl), 8'(tx_level));
            check_val("o_tx_full", 8'(lvl == `UART_FIFO_DEPTH), 8'(tx_full));
            check_val("o_tx_ready", 8'(lvl != `UART_FIFO_DEPTH), 8'(tx_ready));
            if (lvl < `UART_FIFO_DEPTH) begin
                exp_q.push_back(b);
                lvl++;
            end
        end
        @(posedge clk);
        tx_valid <= 1'b0;
        drain_wait();

        @(posedge clk);
        sel_loop <= 1'b0;
        rx_ready <= 1'b0;
        for (i = 0; i < 10; i++) begin
            b = 8'($random(seed));
            if (i < `UART_FIFO_DEPTH) exp_q.push_back(b);  // later bytes are lost
            send_frame(b, 1'b1);
        end
        repeat (BIT_CLKS) @(negedge clk);
        check_val("o_rx_full", 8'd1, 8'(rx_full));
        check_val("o_rx_level", 8'(`UART_FIFO_DEPTH), 8'(rx_level));
        @(posedge clk);
        rx_ready <= 1'b1;
        drain_wait();
        check_val("o_rx_empty", 8'd1, 8'(rx_empty));

        send_frame(8'($random(seed)), 1'b0);  // framing error
        repeat (2 * BIT_CLKS) @(posedge clk);
        ser_line <= 1'b0;                    // quarter bit glitch
        repeat (BIT_CLKS / 4) @(posedge clk);
        ser_line <= 1'b1;
        repeat (2 * BIT_CLKS) @(posedge clk);
        b = 8'($random(seed));
        exp_q.push_back(b);
        send_frame(b, 1'b1);
        drain_wait();
        check_val("o_rx_empty", 8'd1, 8'(rx_empty));

        $display("value errors %0d, receive errors %0d, protocol errors %0d",
                 val_errs, mon_errs, prop_errs);
        if (val_errs + mon_errs + prop_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : uart_tb

/* design/uart_consts.svh */
// uart constants: frame format, oversampling ratio, divisor width and fifo sizing
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

`define UART_DATA_BITS   8    // bits per character, 8n1
`define UART_OVERSAMPLE  16   // sample ticks per bit period
`define UART_DIV_W       16   // width of the baud divisor

`define UART_FIFO_DEPTH  8    // default fifo depth, power of two

// majority vote window inside a bit, in sample counts 1..16
`define UART_SAMP_FIRST  7
`define UART_SAMP_LAST   9

`endif

/* design/uart_fifo.sv */
// uart fifo: circular buffer with valid/ready push and pop sides and occupancy status
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_fifo import uart_pkg::*; #(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  uart_byte_t                 i_push_data,
    input  logic                       i_push_valid,
    output logic                       o_push_ready,
    output uart_byte_t                 o_pop_data,
    output logic                       o_pop_valid,
    input  logic                       i_pop_ready,
    output logic                       o_full,
    output logic                       o_empty,
    output logic [$clog2(DEPTH+1)-1:0] o_level
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int LVL_W = $clog2(DEPTH + 1);

    uart_byte_t        mem [DEPTH];
    logic [PTR_W-1:0]  head_ptr;
    logic [PTR_W-1:0]  tail_ptr;
    logic [LVL_W-1:0]  count;
    logic              push;
    logic              pop;

    assign o_full       = (count == LVL_W'(DEPTH));
    assign o_empty      = (count == '0);
    assign o_level      = count;
    assign o_push_ready = !o_full;
    assign o_pop_valid  = !o_empty;
    assign o_pop_data   = mem[head_ptr];  // head is valid while o_pop_valid

    assign push = i_push_valid && o_push_ready;
    assign pop  = i_pop_ready && o_pop_valid;

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[tail_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) tail_ptr <= tail_ptr + 1'b1;  // wraps, depth is a power of two
            if (pop) head_ptr <= head_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push and pop together
            endcase
        end
    end

endmodule : uart_fifo

/* design/uart_pkg.sv */
// uart package: character type and transmitter/receiver state encodings
`include "uart_consts.svh"

package uart_pkg;

    typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,   // bit index held in a separate counter
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,  // start bit confirmation
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage : uart_pkg

/* design/uart_rx.sv */
// uart receiver: input synchronizer, 3-sample majority vote, frame state machine and shifter
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_rx import uart_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_samp_tick,
    input  logic       i_rx,
    output uart_byte_t o_data,
    output logic       o_data_push
);

    localparam int SAMP_W = $clog2(`UART_OVERSAMPLE) + 1;  // counts 1..16
    localparam int BIT_W  = $clog2(`UART_DATA_BITS);

    localparam logic [SAMP_W-1:0] SAMP_FIRST = SAMP_W'(`UART_SAMP_FIRST);
    localparam logic [SAMP_W-1:0] SAMP_LAST  = SAMP_W'(`UART_SAMP_LAST);
    localparam logic [SAMP_W-1:0] SAMP_PUSH  = SAMP_W'(`UART_SAMP_LAST + 1);
    localparam logic [SAMP_W-1:0] SAMP_END   = SAMP_W'(`UART_OVERSAMPLE);

    logic             rx_meta;
    logic             rx_sync;
    rx_state_t        state;
    logic [SAMP_W-1:0] samp_cnt;
    logic [1:0]       ones_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic             vote;
    logic             in_window;
    logic             bit_end;

    assign vote      = ones_cnt[1];  // two or three of the samples were high
    assign in_window = (samp_cnt >= SAMP_FIRST) && (samp_cnt <= SAMP_LAST);
    assign bit_end   = (samp_cnt == SAMP_END);

    // push one sample after the stop bit vote settles
    assign o_data_push = i_samp_tick && (state == RX_STOP) && (samp_cnt == SAMP_PUSH) && vote;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_samp_tick && state == RX_DATA && bit_end) begin
            o_data <= {vote, o_data[`UART_DATA_BITS-1:1]};  // lsb arrives first
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= RX_IDLE;
            samp_cnt <= '0;
            ones_cnt <= '0;
            bit_cnt  <= '0;
        end else if (i_samp_tick) begin
            samp_cnt <= samp_cnt + 1'b1;
            if (in_window) ones_cnt <= ones_cnt + 2'(rx_sync);

            case (state)
                RX_IDLE: begin
                    samp_cnt <= SAMP_W'(1);  // falling edge sample counts as the first
                    ones_cnt <= '0;
                    if (!rx_sync) state <= RX_START;
                end
                RX_START: begin
                    if (bit_end) begin
                        samp_cnt <= SAMP_W'(1);
                        ones_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= vote ? RX_IDLE : RX_DATA;  // high majority means a glitch
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        samp_cnt <= SAMP_W'(1);
                        ones_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(`UART_DATA_BITS - 1)) state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    // good stop bit leaves early to catch the next start edge,
                    // a framing error waits out the bit and drops the byte
                    if ((samp_cnt == SAMP_PUSH && vote) || bit_end) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule : uart_rx

/* design/uart_tick_gen.sv */
// uart tick generator deriving oversampling ticks and baud ticks from the run-time divisor
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_tick_gen import uart_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic [`UART_DIV_W-1:0] i_baud_div,  // nonzero multiple of 16
    output logic                   o_samp_tick,
    output logic                   o_baud_tick
);

    localparam int SAMP_W = $clog2(`UART_OVERSAMPLE);

    logic [`UART_DIV_W-1:0] pre_cnt;
    logic [`UART_DIV_W-1:0] pre_last;
    logic [SAMP_W-1:0]      samp_cnt;
    logic                   pre_wrap;

    assign pre_last = (i_baud_div >> SAMP_W) - 1'b1;  // div/16 clocks per sample
    assign pre_wrap = (pre_cnt == pre_last);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pre_cnt     <= '0;
            samp_cnt    <= '0;
            o_samp_tick <= 1'b0;
            o_baud_tick <= 1'b0;
        end else begin
            o_samp_tick <= pre_wrap;
            o_baud_tick <= pre_wrap && (samp_cnt == SAMP_W'(`UART_OVERSAMPLE - 1));
            if (pre_wrap) begin
                pre_cnt  <= '0;
                samp_cnt <= samp_cnt + 1'b1;  // wraps every 16 samples
            end else begin
                pre_cnt  <= pre_cnt + 1'b1;
            end
        end
    end

endmodule : uart_tick_gen

/* design/uart_top.sv */
// uart top: tick generator, transmit and receive fifos, transmitter and receiver
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_top import uart_pkg::*; (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,
    input  logic [`UART_DIV_W-1:0]                i_baud_div,
    // host transmit side
    input  uart_byte_t                            i_tx_data,
    input  logic                                  i_tx_valid,
    output logic                                  o_tx_ready,
    output logic                                  o_tx_full,
    output logic                                  o_tx_empty,
    output logic [$clog2(`UART_FIFO_DEPTH+1)-1:0] o_tx_level,
    // host receive side
    output uart_byte_t                            o_rx_data,
    output logic                                  o_rx_valid,
    input  logic                                  i_rx_ready,
    output logic                                  o_rx_full,
    output logic                                  o_rx_empty,
    output logic [$clog2(`UART_FIFO_DEPTH+1)-1:0] o_rx_level,
    // serial line
    input  logic                                  i_rx,
    output logic                                  o_tx
);

    logic       samp_tick;
    logic       baud_tick;
    uart_byte_t tx_head;
    logic       tx_head_valid;
    logic       tx_pop;
    uart_byte_t rx_byte;
    logic       rx_push;

    uart_tick_gen u_tick_gen (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_baud_div  (i_baud_div),
        .o_samp_tick (samp_tick),
        .o_baud_tick (baud_tick)
    );

    uart_fifo #(.DEPTH(`UART_FIFO_DEPTH)) tx_fifo (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_push_data  (i_tx_data),
        .i_push_valid (i_tx_valid),
        .o_push_ready (o_tx_ready),
        .o_pop_data   (tx_head),
        .o_pop_valid  (tx_head_valid),
        .i_pop_ready  (tx_pop),
        .o_full       (o_tx_full),
        .o_empty      (o_tx_empty),
        .o_level      (o_tx_level)
    );

    uart_tx u_tx (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_baud_tick  (baud_tick),
        .i_data       (tx_head),
        .i_data_valid (tx_head_valid),
        .o_data_pop   (tx_pop),
        .o_tx         (o_tx)
    );

    uart_rx u_rx (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_samp_tick (samp_tick),
        .i_rx        (i_rx),
        .o_data      (rx_byte),
        .o_data_push (rx_push)
    );

    // receiver does not wait for space, a byte pushed while full is lost
    uart_fifo #(.DEPTH(`UART_FIFO_DEPTH)) rx_fifo (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_push_data  (rx_byte),
        .i_push_valid (rx_push),
        .o_push_ready (),
        .o_pop_data   (o_rx_data),
        .o_pop_valid  (o_rx_valid),
        .i_pop_ready  (i_rx_ready),
        .o_full       (o_rx_full),
        .o_empty      (o_rx_empty),
        .o_level      (o_rx_level)
    );

endmodule : uart_top

/* design/uart_tx.sv */
// uart transmitter: 8n1 frame state machine with a parallel-to-serial shifter
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_tx import uart_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_baud_tick,
    input  uart_byte_t i_data,
    input  logic       i_data_valid,
    output logic       o_data_pop,
    output logic       o_tx
);

    localparam int BIT_W = $clog2(`UART_DATA_BITS);

    tx_state_t        state;
    logic [BIT_W-1:0] bit_cnt;
    uart_byte_t       shift_q;
    logic             shifting;

    // a new frame may start from idle or straight after a stop bit,
    // so back to back frames stay exactly ten bit periods long
    assign o_data_pop = i_baud_tick && i_data_valid &&
                        (state == TX_IDLE || state == TX_STOP);

    assign shifting = i_baud_tick && (state == TX_START || state == TX_DATA);

    always_ff @(posedge i_clk) begin
        if (o_data_pop) begin
            shift_q <= i_data;
        end else if (shifting) begin
            shift_q <= shift_q >> 1;  // lsb first
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            o_tx    <= 1'b1;  // line idles high
        end else if (i_baud_tick) begin
            case (state)
                TX_IDLE, TX_STOP: begin
                    if (i_data_valid) begin
                        state <= TX_START;
                        o_tx  <= 1'b0;  // start bit
                    end else begin
                        state <= TX_IDLE;
                        o_tx  <= 1'b1;
                    end
                end
                TX_START: begin
                    state   <= TX_DATA;
                    bit_cnt <= '0;
                    o_tx    <= shift_q[0];
                end
                TX_DATA: begin
                    if (bit_cnt == BIT_W'(`UART_DATA_BITS - 1)) begin
                        state <= TX_STOP;
                        o_tx  <= 1'b1;  // stop bit
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        o_tx    <= shift_q[0];
                    end
                end
                default: begin
                    state <= TX_IDLE;
                    o_tx  <= 1'b1;
                end
            endcase
        end
    end

endmodule : uart_tx

/* vlog.f */
+incdir+design
design/uart_pkg.sv
design/uart_tick_gen.sv
design/uart_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
bench/uart_tb.sv
